//--- all.f
+incdir+.
dcache_pkg.sv
dcache_sets.sv
dcache_ctrl.sv
dcache.sv
tb_clock.sv
dcache_chk.sv
tb_dcache.sv

//--- tb_dcache.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module tb_dcache
   import dcache_pkg::*;
();

   localparam int TESTS           = 5;
   localparam int CYCLES_PER_TEST = 400;
   localparam int MEM_WORDS       = 1024;

   logic  CLK;
   logic  nRST;
   logic  dmem_ren;
   logic  dmem_wen;
   addr_t dmem_addr;
   word_t dmem_store;
   logic  halt;
   word_t mem_load;
   logic  mem_wait;
   word_t dmem_load;
   logic  dhit;
   logic  flushed;
   logic  mem_ren;
   logic  mem_wen;
   addr_t mem_addr;
   word_t mem_store;

   // memory model, reference copy and request counters
   word_t  mem       [MEM_WORDS];
   word_t  ref_mem   [MEM_WORDS];
   int     rd_count  [MEM_WORDS];
   int     wr_count  [MEM_WORDS];
   int     wr_before [MEM_WORDS];
   logic   blk_written [MEM_WORDS/2];
   int     reads     = 0;
   int     writes    = 0;
   int     mem_delay = 0;
   logic   mem_busy  = 1'b0;
   integer seed      = 32'h31b6_0d5e;
   int     checks    = 0;
   int     errors    = 0;

   tb_clock i_clock (.CLK(CLK), .nRST(nRST));

   dcache i_dcache (.*);

   function automatic word_t init_word(input addr_t a);
      return a ^ {a[15:0], a[31:16]} ^ 32'hc3a5_0f0f;
   endfunction

   function automatic addr_t make_addr(input int tag_n, input int set_n, input int word_n);
      return addr_t'((tag_n << (`DCACHE_INDEX_W + 3)) | (set_n << 3) | (word_n << 2));
   endfunction

   task automatic check_value(input string name, input word_t got, input word_t exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("FAILED %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   // holds one request until dhit, reads are checked against the reference copy
   task automatic access(input logic we, input addr_t a, input word_t d);
      dmem_ren   = !we;
      dmem_wen   = we;
      dmem_addr  = a;
      dmem_store = d;
      @(negedge CLK);
      while (!dhit)
         @(negedge CLK);
      if (we)
      begin
         ref_mem[a[11:2]]     = d;
         blk_written[a[11:3]] = 1'b1;
      end
      else
         check_value($sformatf("dmem_load at %h", a), dmem_load, ref_mem[a[11:2]]);
      @(posedge CLK);
      #5;
      dmem_ren = 1'b0;
      dmem_wen = 1'b0;
   endtask

   // memory answers each request after 0 to 3 cycles
   always @(posedge CLK)
   begin
      #5;
      if (mem_ren || mem_wen)
      begin
         if (!mem_busy)
         begin
            mem_busy  = 1'b1;
            mem_delay = $random(seed) & 3;
         end
         if (mem_delay == 0)
         begin
            mem_busy = 1'b0;
            if (mem_ren)
            begin
               mem_load = mem[mem_addr[11:2]];
               rd_count[mem_addr[11:2]]++;
               reads++;
            end
            else
            begin
               mem[mem_addr[11:2]] = mem_store;
               wr_count[mem_addr[11:2]]++;
               writes++;
            end
            mem_wait = 1'b0;
         end
         else
         begin
            mem_delay--;
            mem_wait = 1'b1;
         end
      end
      else
         mem_wait = 1'b1;
   end

   task automatic read_miss_test();
      addr_t a;
      int    reads0;
      int    writes0;
      a       = make_addr(4, 1, 0);
      reads0  = reads;
      writes0 = writes;
      access(1'b0, a, '0);
      check_value("memory reads", word_t'(reads - reads0), 2);
      check_value("memory writes", word_t'(writes - writes0), 0);
      check_value($sformatf("reads of %h", a), word_t'(rd_count[a[11:2]]), 1);
      check_value($sformatf("reads of %h", a + 4), word_t'(rd_count[a[11:2] + 1]), 1);
   endtask

   task automatic read_hit_test();
      int reads0;
      int writes0;
      reads0  = reads;
      writes0 = writes;
      access(1'b0, make_addr(4, 1, 1), '0);
      access(1'b0, make_addr(4, 1, 0), '0);
      check_value("memory reads on hit", word_t'(reads - reads0), 0);
      check_value("memory writes on hit", word_t'(writes - writes0), 0);
   endtask

   task automatic write_test();
      addr_t a;
      addr_t b;
      a = make_addr(4, 1, 1);
      b = make_addr(8, 2, 0);
      // write hit on the block from the read tests
      access(1'b1, a, $random(seed));
      access(1'b0, a, '0);
      access(1'b0, a - 4, '0);
      // write miss allocates the block
      access(1'b1, b, $random(seed));
      access(1'b0, b, '0);
      access(1'b0, b + 4, '0);
      check_value($sformatf("writes of %h", a), word_t'(wr_count[a[11:2]]), 0);
      check_value($sformatf("writes of %h", a - 4), word_t'(wr_count[a[11:2] - 1]), 0);
      check_value($sformatf("writes of %h", b), word_t'(wr_count[b[11:2]]), 0);
      check_value($sformatf("writes of %h", b + 4), word_t'(wr_count[b[11:2] + 1]), 0);
   endtask

   task automatic replacement_test();
      addr_t addr_a;
      addr_t addr_b;
      addr_t addr_c;
      int    writes0;
      addr_a = make_addr(0, 3, 0);
      addr_b = make_addr(1, 3, 0);
      addr_c = make_addr(2, 3, 0);
      access(1'b1, addr_a, $random(seed));
      access(1'b0, addr_b, '0);
      access(1'b0, addr_a, '0);
      // B is least recently used and clean
      writes0 = writes;
      access(1'b0, addr_c, '0);
      check_value("writes on clean eviction", word_t'(writes - writes0), 0);
      // now A is least recently used and dirty
      access(1'b0, addr_b, '0);
      check_value("writes on dirty eviction", word_t'(writes - writes0), 2);
      check_value($sformatf("writes of %h", addr_a), word_t'(wr_count[addr_a[11:2]]), 1);
      check_value($sformatf("writes of %h", addr_a + 4),
                  word_t'(wr_count[addr_a[11:2] + 1]), 1);
      check_value($sformatf("memory at %h", addr_a), mem[addr_a[11:2]], ref_mem[addr_a[11:2]]);
      check_value($sformatf("memory at %h", addr_a + 4), mem[addr_a[11:2] + 1],
                  ref_mem[addr_a[11:2] + 1]);
   endtask

   task automatic halt_flush_test();
      access(1'b1, make_addr(0, 5, 0), $random(seed));
      access(1'b1, make_addr(31, 4, 1), $random(seed));
      access(1'b1, make_addr(1, 3, 1), $random(seed));
      wr_before = wr_count;
      halt      = 1'b1;
      @(negedge CLK);
      while (!flushed)
         @(negedge CLK);
      // flushed holds once the flush is done
      repeat (4)
      begin
         @(negedge CLK);
         check_value("flushed", word_t'(flushed), 1);
      end
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         check_value($sformatf("memory at %h", i * 4), mem[i], ref_mem[i]);
         assert (wr_count[i] - wr_before[i] <= 1)
         else
         begin
            errors++;
            $display("word at %h was written more than once by the flush", i * 4);
         end
      end
      // blocks the processor never wrote stay clean
      for (int b = 0; b < MEM_WORDS / 2; b++)
      begin
         if (!blk_written[b])
            check_value($sformatf("writes of clean block %h", b * 8),
                        word_t'(wr_count[2 * b] + wr_count[2 * b + 1]), 0);
      end
   endtask

   initial
   begin
      dmem_ren   = 1'b0;
      dmem_wen   = 1'b0;
      dmem_addr  = '0;
      dmem_store = '0;
      halt       = 1'b0;
      mem_load   = '0;
      mem_wait   = 1'b1;
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         mem[i]      = init_word(addr_t'(i * 4));
         ref_mem[i]  = mem[i];
         rd_count[i] = 0;
         wr_count[i] = 0;
      end
      for (int b = 0; b < MEM_WORDS / 2; b++)
         blk_written[b] = 1'b0;
      @(posedge nRST);
      @(posedge CLK);
      #5;
      read_miss_test();
      read_hit_test();
      write_test();
      replacement_test();
      halt_flush_test();
      $display("checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, i_dcache.i_chk.failures);
      if (errors == 0 && i_dcache.i_chk.failures == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   // watchdog sized from the number of tests plus reset
   initial
   begin
      #(TESTS * CYCLES_PER_TEST * 40 + 8 * 40);
      $display("timeout: the DUT stopped answering requests");
      $display("checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, i_dcache.i_chk.failures);
      $display("test failed");
      $finish;
   end

endmodule

//--- dcache_chk.sv
`timescale 1ns/1ns

module dcache_chk
   import dcache_pkg::*;
(
   input logic  CLK,
   input logic  nRST,
   input logic  mem_ren,
   input logic  mem_wen,
   input logic  mem_wait,
   input addr_t mem_addr,
   input logic  flushed
);

   // failed assertions, summed into the testbench result
   int failures = 0;

   // one memory request at a time
   no_read_and_write: assert property (@(posedge CLK) disable iff (!nRST)
      !(mem_ren && mem_wen))
   else
   begin
      failures++;
      $error("memory read and write requested in the same cycle");
   end

   // flushed only falls on reset
   flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
      flushed |=> flushed)
   else
   begin
      failures++;
      $error("flushed fell after the flush was done");
   end

   // memory side is word addressed
   word_aligned: assert property (@(posedge CLK) disable iff (!nRST)
      (mem_ren || mem_wen) |-> (mem_addr[1:0] == 2'b00))
   else
   begin
      failures++;
      $error("memory request with a byte offset in its address");
   end

   // a stalled request keeps its address
   addr_held: assert property (@(posedge CLK) disable iff (!nRST)
      ((mem_ren || mem_wen) && mem_wait) |=> $stable(mem_addr))
   else
   begin
      failures++;
      $error("memory address changed while the request was stalled");
   end

endmodule

bind dcache dcache_chk i_chk (.*);

//--- tb_clock.sv
`timescale 1ns/1ns

module tb_clock
(
   output logic CLK,
   output logic nRST
);

   // 40 ns period
   initial
   begin
      CLK = 1'b0;
      forever #20 CLK = ~CLK;
   end

   // reset held for 8 cycles, released off the edge
   initial
   begin
      nRST = 1'b0;
      repeat (8) @(posedge CLK);
      #5 nRST = 1'b1;
   end

endmodule

//--- dcache.sv
`timescale 1ns/1ns

module dcache
   import dcache_pkg::*;
(
   input  logic  CLK,
   input  logic  nRST,
   input  logic  dmem_ren,
   input  logic  dmem_wen,
   input  addr_t dmem_addr,
   input  word_t dmem_store,
   input  logic  halt,
   input  word_t mem_load,
   input  logic  mem_wait,
   output word_t dmem_load,
   output logic  dhit,
   output logic  flushed,
   output logic  mem_ren,
   output logic  mem_wen,
   output addr_t mem_addr,
   output word_t mem_store
);

   // storage control from the controller
   set_idx_t index;
   logic     rd_way;
   logic     rd_word;
   logic     wr_en;
   logic     wr_way;
   logic     wr_word;
   word_t    wr_data;
   tag_t     fill_tag;
   logic     fill_done;
   logic     clean_en;
   logic     clean_way;
   logic     touch_en;
   logic     touch_way;

   // indexed set fields back to the controller
   tag_t       tag0;
   tag_t       tag1;
   logic [1:0] valid;
   logic [1:0] dirty;
   logic       lru_way;
   word_t      rd_data;

   dcache_ctrl i_ctrl (.*);

   dcache_sets i_sets (.*);

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_ctrl
   import dcache_pkg::*;
(
   input  logic                    CLK,
   input  logic                    nRST,
   input  logic                    dmem_ren,
   input  logic                    dmem_wen,
   input  addr_t                   dmem_addr,
   input  word_t                   dmem_store,
   input  logic                    halt,
   input  word_t                   mem_load,
   input  logic                    mem_wait,
   input  tag_t                    tag0,
   input  tag_t                    tag1,
   input  logic [`DCACHE_WAYS-1:0] valid,
   input  logic [`DCACHE_WAYS-1:0] dirty,
   input  logic                    lru_way,
   input  word_t                   rd_data,
   output word_t                   dmem_load,
   output logic                    dhit,
   output logic                    flushed,
   output logic                    mem_ren,
   output logic                    mem_wen,
   output addr_t                   mem_addr,
   output word_t                   mem_store,
   output set_idx_t                index,
   output logic                    rd_way,
   output logic                    rd_word,
   output logic                    wr_en,
   output logic                    wr_way,
   output logic                    wr_word,
   output word_t                   wr_data,
   output tag_t                    fill_tag,
   output logic                    fill_done,
   output logic                    clean_en,
   output logic                    clean_way,
   output logic                    touch_en,
   output logic                    touch_way
);

   dcache_state_t state;
   dcache_state_t next_state;
   addr_t         miss_addr;
   logic          wr_miss;
   slot_t         slot;

   tag_t req_tag;
   tag_t victim_tag;
   tag_t scan_tag;
   logic hit0;
   logic hit1;
   logic hit;
   logic req;
   logic scan_way;

   assign req     = dmem_ren || dmem_wen;
   assign req_tag = dmem_addr[31:6];

   // only meaningful in IDLE, where the index follows the request
   assign hit0 = valid[0] && (tag0 == req_tag);
   assign hit1 = valid[1] && (tag1 == req_tag);
   assign hit  = req && (hit0 || hit1);

   // slot bit 3 picks the way, bits 2 to 0 the set
   assign scan_way   = slot[3];
   assign victim_tag = lru_way ? tag1 : tag0;
   assign scan_tag   = scan_way ? tag1 : tag0;

   assign dmem_load = rd_data;

   always_comb
   begin
      case (state)
         IDLE:                         index = dmem_addr[5:3];
         SCAN, FLUSH1, FLUSH2, HALTED: index = slot[2:0];
         default:                      index = miss_addr[5:3];
      endcase
   end

   always_comb
   begin
      next_state = state;
      case (state)
         IDLE:
         begin
            if (halt)
               next_state = SCAN;
            else if (req && !hit)
               next_state = (valid[lru_way] && dirty[lru_way]) ? WB1 : READ1;
         end
         WB1:    if (!mem_wait) next_state = WB2;
         WB2:    if (!mem_wait) next_state = READ1;
         READ1:  if (!mem_wait) next_state = READ2;
         READ2:  if (!mem_wait) next_state = IDLE;
         SCAN:
         begin
            if (slot == slot_t'(`DCACHE_SLOTS))
               next_state = HALTED;
            else if (valid[scan_way] && dirty[scan_way])
               next_state = FLUSH1;
         end
         FLUSH1: if (!mem_wait) next_state = FLUSH2;
         FLUSH2: if (!mem_wait) next_state = SCAN;
         HALTED: next_state = HALTED;
         default: next_state = IDLE;
      endcase
   end

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state   <= IDLE;
         wr_miss <= 1'b0;
         slot    <= '0;
      end
      else
      begin
         state <= next_state;
         if (state == IDLE && req)
            wr_miss <= dmem_wen;
         // the scan moves on after a clean block or a finished flush
         if (state == IDLE)
            slot <= '0;
         else if (state == SCAN && next_state == SCAN)
            slot <= slot + 1'b1;
         else if (state == FLUSH2 && !mem_wait)
            slot <= slot + 1'b1;
      end
   end

   // the miss address is captured on the request that leaves IDLE
   always_ff @(posedge CLK)
   begin
      if (state == IDLE)
         miss_addr <= dmem_addr;
   end

   always_comb
   begin
      dhit      = 1'b0;
      flushed   = 1'b0;
      mem_ren   = 1'b0;
      mem_wen   = 1'b0;
      mem_addr  = '0;
      mem_store = '0;
      rd_way    = hit1;
      rd_word   = dmem_addr[2];
      wr_en     = 1'b0;
      wr_way    = hit1;
      wr_word   = dmem_addr[2];
      wr_data   = dmem_store;
      fill_tag  = miss_addr[31:6];
      fill_done = 1'b0;
      clean_en  = 1'b0;
      clean_way = lru_way;
      touch_en  = 1'b0;
      touch_way = hit1;
      case (state)
         IDLE:
         begin
            if (!halt && hit)
            begin
               dhit     = 1'b1;
               touch_en = 1'b1;
               wr_en    = dmem_wen;
            end
         end
         WB1, WB2:
         begin
            mem_wen   = 1'b1;
            rd_way    = lru_way;
            rd_word   = (state == WB2);
            mem_addr  = {victim_tag, miss_addr[5:3], rd_word, 2'b00};
            mem_store = rd_data;
            clean_en  = (state == WB2) && !mem_wait;
         end
         READ1, READ2:
         begin
            // word 0 sets dirty on a write miss, a read miss clears it again
            mem_ren   = 1'b1;
            wr_word   = (state == READ2);
            mem_addr  = {miss_addr[31:3], wr_word, 2'b00};
            wr_en     = !mem_wait;
            wr_way    = lru_way;
            wr_data   = mem_load;
            fill_done = (state == READ2) && !mem_wait;
            clean_en  = (state == READ1) && !mem_wait && !wr_miss;
         end
         FLUSH1, FLUSH2:
         begin
            mem_wen   = 1'b1;
            rd_way    = scan_way;
            rd_word   = (state == FLUSH2);
            mem_addr  = {scan_tag, slot[2:0], rd_word, 2'b00};
            mem_store = rd_data;
            clean_en  = (state == FLUSH2) && !mem_wait;
            clean_way = scan_way;
         end
         HALTED: flushed = 1'b1;
         default: flushed = 1'b0;
      endcase
   end

endmodule

//--- dcache_sets.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_sets
   import dcache_pkg::*;
(
   input  logic                    CLK,
   input  logic                    nRST,
   input  set_idx_t                index,
   input  logic                    rd_way,
   input  logic                    rd_word,
   input  logic                    wr_en,
   input  logic                    wr_way,
   input  logic                    wr_word,
   input  word_t                   wr_data,
   input  tag_t                    fill_tag,
   input  logic                    fill_done,
   input  logic                    clean_en,
   input  logic                    clean_way,
   input  logic                    touch_en,
   input  logic                    touch_way,
   output tag_t                    tag0,
   output tag_t                    tag1,
   output logic [`DCACHE_WAYS-1:0] valid,
   output logic [`DCACHE_WAYS-1:0] dirty,
   output logic                    lru_way,
   output word_t                   rd_data
);

   // per set and way
   tag_t                    tag_q   [`DCACHE_SETS][`DCACHE_WAYS];
   word_t                   data_q  [`DCACHE_SETS][`DCACHE_WAYS][2];
   logic [`DCACHE_WAYS-1:0] valid_q [`DCACHE_SETS];
   logic [`DCACHE_WAYS-1:0] dirty_q [`DCACHE_SETS];

   // per set, the way to replace next
   logic [`DCACHE_SETS-1:0] lru_q;

   // tag, valid and dirty bits
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         for (int s = 0; s < `DCACHE_SETS; s++)
         begin
            valid_q[s] <= '0;
            dirty_q[s] <= '0;
            for (int w = 0; w < `DCACHE_WAYS; w++)
            begin
               tag_q[s][w] <= '0;
            end
         end
      end
      else
      begin
         // a processor write makes the block dirty, a memory fill does not
         if (wr_en && !fill_done)
         begin
            dirty_q[index][wr_way] <= 1'b1;
         end
         if (fill_done)
         begin
            tag_q[index][wr_way]   <= fill_tag;
            valid_q[index][wr_way] <= 1'b1;
         end
         // clean comes last so it wins over a write to the same way
         if (clean_en)
         begin
            dirty_q[index][clean_way] <= 1'b0;
         end
      end
   end

   // block data
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         for (int s = 0; s < `DCACHE_SETS; s++)
         begin
            for (int w = 0; w < `DCACHE_WAYS; w++)
            begin
               data_q[s][w][0] <= '0;
               data_q[s][w][1] <= '0;
            end
         end
      end
      else if (wr_en)
      begin
         data_q[index][wr_way][wr_word] <= wr_data;
      end
   end

   // replacement bits point away from the way last used
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         lru_q <= '0;
      end
      else if (touch_en)
      begin
         lru_q[index] <= ~touch_way;
      end
   end

   // fields of the indexed set
   assign tag0    = tag_q[index][0];
   assign tag1    = tag_q[index][1];
   assign valid   = valid_q[index];
   assign dirty   = dirty_q[index];
   assign lru_way = lru_q[index];

   assign rd_data = data_q[index][rd_way][rd_word];

endmodule

//--- dcache_pkg.sv
`include "dcache_defines.svh"

package dcache_pkg;

   // address and data
   typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
   typedef logic [`DCACHE_WORD_W-1:0] word_t;

   // block fields taken from an address
   typedef logic [`DCACHE_TAG_W-1:0]   tag_t;
   typedef logic [`DCACHE_INDEX_W-1:0] set_idx_t;

   // one extra bit so the scan can run one past the last block
   typedef logic [$clog2(`DCACHE_SLOTS):0] slot_t;

   // controller states
   typedef enum logic [3:0] {
      IDLE,
      WB1,
      WB2,
      READ1,
      READ2,
      SCAN,
      FLUSH1,
      FLUSH2,
      HALTED
   } dcache_state_t;

endpackage

//--- dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// byte address and data word
`define DCACHE_ADDR_W 32
`define DCACHE_WORD_W 32

// geometry: 8 sets of two ways, two words per block
`define DCACHE_SETS 8
`define DCACHE_WAYS 2

// set index is address bits 5 to 3
`define DCACHE_INDEX_W 3

// tag is address bits 31 to 6
`define DCACHE_TAG_W 26

// blocks visited by the halt flush (ways times sets)
`define DCACHE_SLOTS 16

`endif
